// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_nic_ctrl
FILELIST = nic_ctrl_top.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: nic_ctrl_assertions.sv
`default_nettype none

module nic_ctrl_assertions
	import nic_pkg::*;
(
	input logic      aclk,
	input logic      reset_i,
	input axil_req_t axil_req_i,
	input axil_rsp_t axil_rsp_i,
	input logic      reset_request_i,
	input logic      mdc_i,
	input logic      mdio_oe_i,
	input mdio_req_t mdio_req_i,
	input mdio_rsp_t mdio_rsp_i
);
	timeunit 1ns;
	timeprecision 1ps;

	logic       mdc_prev;
	logic       rd_frame;
	logic [6:0] fall_cnt;

	// Falling MDC edges since start, one cycle late
	always_ff @(posedge aclk)
	begin
		if (reset_i)
		begin
			mdc_prev <= 1'b0;
			rd_frame <= 1'b0;
			fall_cnt <= '0;
		end
		else
		begin
			mdc_prev <= mdc_i;
			if (mdio_req_i.start)
			begin
				rd_frame <= (mdio_req_i.op == MDIC_READ);
				fall_cnt <= '0;
			end
			else if (mdc_prev && !mdc_i)
				fall_cnt <= fall_cnt + 7'd1;
		end
	end

	bvalid_hold: assert property (@(posedge aclk) disable iff (reset_i)
		axil_rsp_i.bvalid && !axil_req_i.bready |=> axil_rsp_i.bvalid)
		else $error("bvalid dropped before bready");

	rvalid_hold: assert property (@(posedge aclk) disable iff (reset_i)
		axil_rsp_i.rvalid && !axil_req_i.rready |=> axil_rsp_i.rvalid)
		else $error("rvalid dropped before rready");

	rst_req_pulse: assert property (@(posedge aclk) disable iff (reset_i)
		reset_request_i |=> !reset_request_i)
		else $error("reset_request_o longer than one cycle");

	mdc_idle: assert property (@(posedge aclk) disable iff (reset_i)
		!mdio_rsp_i.busy |-> !mdc_i)
		else $error("mdc_o toggles while the MDIO master is idle");

	// Data phase of a read frame
	oe_read_data: assert property (@(posedge aclk) disable iff (reset_i)
		mdio_rsp_i.busy && rd_frame && fall_cnt >= 7'd48 |-> !mdio_oe_i)
		else $error("mdio_oe_o high during read data");

endmodule

bind nic_ctrl_top nic_ctrl_assertions asrt0 (
	.aclk(aclk),
	.reset_i(reset_i),
	.axil_req_i(axil_i),
	.axil_rsp_i(axil_o),
	.reset_request_i(reset_request_o),
	.mdc_i(mdc_o),
	.mdio_oe_i(mdio_oe_o),
	.mdio_req_i(mdio_req),
	.mdio_rsp_i(mdio_rsp)
);

`default_nettype wire

// File: nic_ctrl_top.f
nic_pkg.sv
nic_regs.sv
nic_intr_ctrl.sv
nic_mdio_master.sv
nic_ctrl_top.sv
nic_ctrl_assertions.sv
tb_nic_ctrl.sv

// File: nic_ctrl_top.sv
`default_nettype none

module nic_ctrl_top
	import nic_pkg::*;
#(
	parameter logic [4:0] PHY_ADDR = 5'd1,
	parameter int MDC_DIV = 4
)
(
	input  logic      aclk,
	input  logic      reset_i,
	input  axil_req_t axil_i,
	output axil_rsp_t axil_o,
	input  logic      phy_int_i,
	input  logic      mdio_i,
	output logic      intr_o,
	output logic      reset_request_o,
	output logic      phy_reset_o,
	output logic      mdc_o,
	output logic      mdio_o,
	output logic      mdio_oe_o
);

	intr_cmd_t   intr_cmd;
	logic [31:0] icr;
	logic [31:0] ims;
	mdio_req_t   mdio_req;
	mdio_rsp_t   mdio_rsp;

	// Host registers
	nic_regs #(
		.PHY_ADDR(PHY_ADDR)
	) regs0 (
		.aclk(aclk),
		.reset_i(reset_i),
		.axil_i(axil_i),
		.axil_o(axil_o),
		.icr_i(icr),
		.ims_i(ims),
		.mdio_rsp_i(mdio_rsp),
		.intr_cmd_o(intr_cmd),
		.mdio_req_o(mdio_req),
		.reset_request_o(reset_request_o),
		.phy_reset_o(phy_reset_o)
	);

	// End of an MDIO frame raises MDAC
	nic_intr_ctrl intr0 (
		.aclk(aclk),
		.reset_i(reset_i),
		.intr_cmd_i(intr_cmd),
		.mdac_i(mdio_rsp.done),
		.phy_int_i(phy_int_i),
		.icr_o(icr),
		.ims_o(ims),
		.intr_o(intr_o)
	);

	nic_mdio_master #(
		.PHY_ADDR(PHY_ADDR),
		.MDC_DIV(MDC_DIV)
	) mdio0 (
		.aclk(aclk),
		.reset_i(reset_i),
		.req_i(mdio_req),
		.mdio_i(mdio_i),
		.rsp_o(mdio_rsp),
		.mdc_o(mdc_o),
		.mdio_o(mdio_o),
		.mdio_oe_o(mdio_oe_o)
	);

endmodule

`default_nettype wire

// File: nic_intr_ctrl.sv
`default_nettype none

module nic_intr_ctrl
	import nic_pkg::*;
(
	input  logic        aclk,
	input  logic        reset_i,
	input  intr_cmd_t   intr_cmd_i,
	input  logic        mdac_i,
	input  logic        phy_int_i,
	output logic [31:0] icr_o,
	output logic [31:0] ims_o,
	output logic        intr_o
);

	logic [1:0]  phy_sync_q;
	logic        phy_prev_q;
	logic        phy_rise;
	logic [31:0] icr_q;
	logic [31:0] ims_q;
	logic [31:0] set_bits;
	logic [31:0] clr_bits;
	logic        intr_q;

	// Two-flop synchroniser, then edge detect
	always_ff @(posedge aclk)
	begin
		if (reset_i)
		begin
			phy_sync_q <= '0;
			phy_prev_q <= 1'b0;
		end
		else
		begin
			phy_sync_q <= {phy_sync_q[0], phy_int_i};
			phy_prev_q <= phy_sync_q[1];
		end
	end

	assign phy_rise = phy_sync_q[1] & ~phy_prev_q;

	// Hardware and software causes, read clears everything
	always_comb
	begin
		set_bits = '0;
		clr_bits = '0;
		set_bits[CAUSE_MDAC] = mdac_i;
		set_bits[CAUSE_PHYINT] = phy_rise;
		case (intr_cmd_i.op)
			INTR_ICS: set_bits = set_bits | intr_cmd_i.data;
			INTR_ICR_READ: clr_bits = '1;
			default: ;
		endcase
	end

	// New causes win over a clear in the same cycle
	always_ff @(posedge aclk)
	begin
		if (reset_i)
			icr_q <= '0;
		else
			icr_q <= (icr_q & ~clr_bits) | set_bits;
	end

	always_ff @(posedge aclk)
	begin
		if (reset_i)
			ims_q <= '0;
		else if (intr_cmd_i.op == INTR_IMS)
			ims_q <= ims_q | intr_cmd_i.data;
		else if (intr_cmd_i.op == INTR_IMC)
			ims_q <= ims_q & ~intr_cmd_i.data;
	end

	// One cycle behind cause and mask
	always_ff @(posedge aclk)
	begin
		if (reset_i)
			intr_q <= 1'b0;
		else
			intr_q <= |(icr_q & ims_q);
	end

	assign icr_o = icr_q;
	assign ims_o = ims_q;
	assign intr_o = intr_q;

endmodule

`default_nettype wire

// File: nic_mdio_master.sv
`default_nettype none

module nic_mdio_master
	import nic_pkg::*;
#(
	parameter logic [4:0] PHY_ADDR = 5'd1,
	parameter int MDC_DIV = 4
)
(
	input  logic      aclk,
	input  logic      reset_i,
	input  mdio_req_t req_i,
	input  logic      mdio_i,
	output mdio_rsp_t rsp_o,
	output logic      mdc_o,
	output logic      mdio_o,
	output logic      mdio_oe_o
);

	localparam int DIV_W = $clog2(MDC_DIV + 1);
	// Bit index on the line: turnaround, data, end of frame
	localparam logic [5:0] TA_BIT   = 6'd46;
	localparam logic [5:0] DATA_BIT = 6'd48;
	localparam logic [5:0] LAST_BIT = 6'd63;

	logic [63:0]      frame;
	logic [63:0]      sr_q;
	logic [DIV_W-1:0] div_cnt_q;
	logic [5:0]       bit_cnt_q;
	logic             busy_q;
	logic             mdc_q;
	logic             oe_q;
	logic             done_q;
	logic             is_read_q;
	logic [15:0]      rdata_q;
	logic             tick;
	logic             rise;
	logic             fall;

	// Preamble, ST, OP, PHYAD, REGAD, TA, DATA
	always_comb
	begin
		if (req_i.op == MDIC_READ)
			frame = {32'hFFFF_FFFF, 2'b01, req_i.op, PHY_ADDR, req_i.regad, 2'b11, 16'hFFFF};
		else
			frame = {32'hFFFF_FFFF, 2'b01, req_i.op, PHY_ADDR, req_i.regad, 2'b10, req_i.data};
	end

	// Half MDC period elapsed
	assign tick = busy_q && (div_cnt_q == DIV_W'(MDC_DIV - 1));
	assign rise = tick && !mdc_q;
	assign fall = tick && mdc_q;

	always_ff @(posedge aclk)
	begin
		if (reset_i)
		begin
			busy_q <= 1'b0;
			mdc_q <= 1'b0;
			oe_q <= 1'b0;
			done_q <= 1'b0;
			div_cnt_q <= '0;
			bit_cnt_q <= '0;
		end
		else
		begin
			done_q <= 1'b0;
			if (req_i.start)
			begin
				// First bit goes out at once, MDC starts low
				busy_q <= 1'b1;
				mdc_q <= 1'b0;
				oe_q <= 1'b1;
				div_cnt_q <= '0;
				bit_cnt_q <= '0;
			end
			else if (busy_q)
			begin
				div_cnt_q <= tick ? '0 : div_cnt_q + 1'b1;
				if (tick)
					mdc_q <= !mdc_q;
				if (fall)
				begin
					bit_cnt_q <= bit_cnt_q + 1'b1;
					// PHY owns the line from TA on
					if (is_read_q && bit_cnt_q == TA_BIT - 1'b1)
						oe_q <= 1'b0;
					if (bit_cnt_q == LAST_BIT)
					begin
						busy_q <= 1'b0;
						oe_q <= 1'b0;
						done_q <= 1'b1;
					end
				end
			end
		end
	end

	// Shift on falling MDC, sample read data on rising MDC
	always_ff @(posedge aclk)
	begin
		if (req_i.start)
		begin
			sr_q <= frame;
			is_read_q <= (req_i.op == MDIC_READ);
		end
		else if (fall)
			sr_q <= {sr_q[62:0], 1'b1};
		if (rise && is_read_q && bit_cnt_q >= DATA_BIT)
			rdata_q <= {rdata_q[14:0], mdio_i};
	end

	assign mdc_o = mdc_q;
	assign mdio_o = oe_q & sr_q[63];
	assign mdio_oe_o = oe_q;

	assign rsp_o.busy = busy_q;
	assign rsp_o.done = done_q;
	assign rsp_o.rdata = rdata_q;

endmodule

`default_nettype wire

// File: nic_pkg.sv
`default_nettype none

package nic_pkg;

	// Register offsets on the host port
	typedef enum logic [15:0] {
		CTRL = 16'h0000,
		MDIC = 16'h0020,
		ICR  = 16'h00C0,
		ICS  = 16'h00C8,
		IMS  = 16'h00D0,
		IMC  = 16'h00D8
	} reg_addr_e;

	// Clause-22 opcodes, the other two codes are illegal
	typedef enum logic [1:0] {
		MDIC_WRITE = 2'b01,
		MDIC_READ  = 2'b10
	} mdic_op_e;

	// Actions forwarded to the interrupt controller
	typedef enum logic [2:0] {
		INTR_NONE,
		INTR_ICS,
		INTR_IMS,
		INTR_IMC,
		INTR_ICR_READ
	} intr_op_e;

	// Host to slave
	typedef struct packed {
		logic [15:0] awaddr;
		logic        awvalid;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
		logic        wvalid;
		logic        bready;
		logic [15:0] araddr;
		logic        arvalid;
		logic        rready;
	} axil_req_t;

	// Slave to host
	typedef struct packed {
		logic        awready;
		logic        wready;
		logic [1:0]  bresp;
		logic        bvalid;
		logic        arready;
		logic [31:0] rdata;
		logic [1:0]  rresp;
		logic        rvalid;
	} axil_rsp_t;

	typedef struct packed {
		intr_op_e    op;
		logic [31:0] data;
	} intr_cmd_t;

	typedef struct packed {
		logic        start;
		mdic_op_e    op;
		logic [4:0]  regad;
		logic [15:0] data;
	} mdio_req_t;

	typedef struct packed {
		logic        busy;
		logic        done;
		logic [15:0] rdata;
	} mdio_rsp_t;

	// Cause bits in ICR, ICS, IMS and IMC
	localparam int CAUSE_MDAC   = 9;
	localparam int CAUSE_PHYINT = 12;

	// MDIC layout, data sits in 15:0
	localparam int MDIC_REGAD_LSB = 16;
	localparam int MDIC_PHYAD_LSB = 21;
	localparam int MDIC_OP_LSB    = 26;
	localparam int MDIC_R_BIT     = 28;
	localparam int MDIC_E_BIT     = 30;

endpackage

`default_nettype wire

// File: nic_regs.sv
`default_nettype none

module nic_regs
	import nic_pkg::*;
#(
	parameter logic [4:0] PHY_ADDR = 5'd1
)
(
	input  logic      aclk,
	input  logic      reset_i,
	input  axil_req_t axil_i,
	output axil_rsp_t axil_o,
	input  logic [31:0] icr_i,
	input  logic [31:0] ims_i,
	input  mdio_rsp_t mdio_rsp_i,
	output intr_cmd_t intr_cmd_o,
	output mdio_req_t mdio_req_o,
	output logic      reset_request_o,
	output logic      phy_reset_o
);

	localparam int CTRL_RST_BIT     = 26;
	localparam int CTRL_PHY_RST_BIT = 31;
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	typedef enum logic {W_IDLE, W_RESP} wr_state_e;
	typedef enum logic {R_IDLE, R_RESP} rd_state_e;

	wr_state_e   wr_state_q;
	rd_state_e   rd_state_q;
	logic        wr_accept;
	logic        wr_intr;
	logic        rd_accept;
	logic [1:0]  bresp_q;
	logic [1:0]  rresp_q;
	logic [31:0] rdata_q;
	logic [31:0] rd_word;

	logic [31:0] ctrl_q;
	logic [31:0] ctrl_wr;
	logic        rst_req_q;

	logic [15:0] mdic_data_q;
	logic [4:0]  mdic_regad_q;
	logic [1:0]  mdic_op_q;
	logic        mdic_r_q;
	logic        mdic_e_q;
	logic        mdio_start_q;
	logic [31:0] mdic_img;
	logic [31:0] mdic_wr;
	logic        mdic_op_ok;

	// Byte-lane merge of a write into a stored word
	function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
		input logic [31:0] new_val, input logic [3:0] strb);
		logic [31:0] res;
		res = old_val;
		for (int i = 0; i < 4; i++)
		begin
			if (strb[i])
				res[8*i +: 8] = new_val[8*i +: 8];
		end
		return res;
	endfunction

	function automatic logic is_mapped(input logic [15:0] addr);
		case (addr)
			CTRL, MDIC, ICR, ICS, IMS, IMC: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// Write needs both address and data in the same cycle
	assign wr_accept = (wr_state_q == W_IDLE) && axil_i.awvalid && axil_i.wvalid;
	assign wr_intr = wr_accept && (axil_i.awaddr == ICS || axil_i.awaddr == IMS ||
		axil_i.awaddr == IMC);
	// ICR read waits while a write owns the command slot
	assign rd_accept = (rd_state_q == R_IDLE) && axil_i.arvalid &&
		!(wr_intr && axil_i.araddr == ICR);

	// MDIC as the host sees it
	always_comb
	begin
		mdic_img = '0;
		mdic_img[15:0] = mdic_data_q;
		mdic_img[MDIC_REGAD_LSB +: 5] = mdic_regad_q;
		mdic_img[MDIC_PHYAD_LSB +: 5] = PHY_ADDR;
		mdic_img[MDIC_OP_LSB +: 2] = mdic_op_q;
		mdic_img[MDIC_R_BIT] = mdic_r_q;
		mdic_img[MDIC_E_BIT] = mdic_e_q;
	end

	assign ctrl_wr = merge_bytes(ctrl_q, axil_i.wdata, axil_i.wstrb);
	assign mdic_wr = merge_bytes(mdic_img, axil_i.wdata, axil_i.wstrb);
	assign mdic_op_ok = (mdic_wr[MDIC_OP_LSB +: 2] == MDIC_WRITE) ||
		(mdic_wr[MDIC_OP_LSB +: 2] == MDIC_READ);

	// Read mux, write-only and unmapped offsets give zero
	always_comb
	begin
		case (axil_i.araddr)
			CTRL: rd_word = ctrl_q;
			MDIC: rd_word = mdic_img;
			ICR: rd_word = icr_i;
			IMS: rd_word = ims_i;
			default: rd_word = '0;
		endcase
	end

	// One-cycle command towards the interrupt block
	always_comb
	begin
		intr_cmd_o.op = INTR_NONE;
		intr_cmd_o.data = axil_i.wdata;
		if (rd_accept && axil_i.araddr == ICR)
			intr_cmd_o.op = INTR_ICR_READ;
		if (wr_accept)
		begin
			case (axil_i.awaddr)
				ICS: intr_cmd_o.op = INTR_ICS;
				IMS: intr_cmd_o.op = INTR_IMS;
				IMC: intr_cmd_o.op = INTR_IMC;
				default: ;
			endcase
		end
	end

	// Write channel
	always_ff @(posedge aclk)
	begin
		if (reset_i)
			wr_state_q <= W_IDLE;
		else if (wr_state_q == W_IDLE && wr_accept)
			wr_state_q <= W_RESP;
		else if (wr_state_q == W_RESP && axil_i.bready)
			wr_state_q <= W_IDLE;
	end

	always_ff @(posedge aclk)
	begin
		if (wr_accept)
			bresp_q <= is_mapped(axil_i.awaddr) ? RESP_OKAY : RESP_SLVERR;
	end

	// Read channel, data captured at accept so ICR is the pre-clear value
	always_ff @(posedge aclk)
	begin
		if (reset_i)
			rd_state_q <= R_IDLE;
		else if (rd_state_q == R_IDLE && rd_accept)
			rd_state_q <= R_RESP;
		else if (rd_state_q == R_RESP && axil_i.rready)
			rd_state_q <= R_IDLE;
	end

	always_ff @(posedge aclk)
	begin
		if (rd_accept)
		begin
			rdata_q <= rd_word;
			rresp_q <= is_mapped(axil_i.araddr) ? RESP_OKAY : RESP_SLVERR;
		end
	end

	// CTRL, reset bit self-clears and only pulses the request
	always_ff @(posedge aclk)
	begin
		if (reset_i)
		begin
			ctrl_q <= '0;
			rst_req_q <= 1'b0;
		end
		else
		begin
			rst_req_q <= 1'b0;
			if (wr_accept && axil_i.awaddr == CTRL)
			begin
				ctrl_q <= ctrl_wr;
				ctrl_q[CTRL_RST_BIT] <= 1'b0;
				rst_req_q <= ctrl_wr[CTRL_RST_BIT];
			end
		end
	end

	// MDIC image and start pulse
	always_ff @(posedge aclk)
	begin
		if (reset_i)
		begin
			mdic_data_q <= '0;
			mdic_regad_q <= '0;
			mdic_op_q <= '0;
			mdic_r_q <= 1'b1;
			mdic_e_q <= 1'b0;
			mdio_start_q <= 1'b0;
		end
		else
		begin
			mdio_start_q <= 1'b0;
			if (mdio_rsp_i.done)
			begin
				mdic_r_q <= 1'b1;
				if (mdic_op_q == MDIC_READ)
					mdic_data_q <= mdio_rsp_i.rdata;
			end
			// Dropped while a frame runs or is about to start
			if (wr_accept && axil_i.awaddr == MDIC && !mdio_rsp_i.busy && !mdio_start_q)
			begin
				mdic_data_q <= mdic_wr[15:0];
				mdic_regad_q <= mdic_wr[MDIC_REGAD_LSB +: 5];
				mdic_op_q <= mdic_wr[MDIC_OP_LSB +: 2];
				if (mdic_op_ok)
				begin
					mdic_r_q <= 1'b0;
					mdic_e_q <= 1'b0;
					mdio_start_q <= 1'b1;
				end
				else
					mdic_e_q <= 1'b1;
			end
		end
	end

	always_comb
	begin
		axil_o.awready = wr_accept;
		axil_o.wready = wr_accept;
		axil_o.bresp = bresp_q;
		axil_o.bvalid = (wr_state_q == W_RESP);
		axil_o.arready = rd_accept;
		axil_o.rdata = rdata_q;
		axil_o.rresp = rresp_q;
		axil_o.rvalid = (rd_state_q == R_RESP);
	end

	assign mdio_req_o.start = mdio_start_q;
	assign mdio_req_o.op = mdic_op_e'(mdic_op_q);
	assign mdio_req_o.regad = mdic_regad_q;
	assign mdio_req_o.data = mdic_data_q;

	assign reset_request_o = rst_req_q;
	// PHY held in reset by software or by the system reset
	assign phy_reset_o = ctrl_q[CTRL_PHY_RST_BIT] | reset_i;

endmodule

`default_nettype wire

// File: tb_nic_ctrl.sv
`default_nettype none

module tb_nic_ctrl
	import nic_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [4:0] PHY_ADDR = 5'd5;
	localparam int MDC_DIV = 4;
	localparam int N_MDIO_WR = 4;
	localparam int N_MDIO_RD = 4;
	// One frame is 64 MDC periods of 2*MDC_DIV cycles
	localparam int TIMEOUT_CYCLES = (N_MDIO_WR + N_MDIO_RD) * 128 * MDC_DIV + 2000;

	logic        aclk;
	logic        reset;
	axil_req_t   axil_req;
	axil_rsp_t   axil_rsp;
	logic        phy_int;
	logic        mdio_in;
	logic        intr;
	logic        reset_request;
	logic        phy_reset;
	logic        mdc;
	logic        mdio_out;
	logic        mdio_oe;

	logic [31:0] rand_state;
	string       test_name;
	int          errors;
	int          checks;
	int          errors_at_start;
	int          cycle_cnt;
	int          rst_pulses;

	// PHY model state
	logic [15:0] phy_regs [32];
	int          phy_writes;
	int          phy_reads;
	logic [1:0]  phy_last_op;
	logic [4:0]  phy_last_phyad;
	logic [4:0]  phy_last_regad;
	logic [15:0] phy_last_data;

	nic_ctrl_top #(
		.PHY_ADDR(PHY_ADDR),
		.MDC_DIV(MDC_DIV)
	) dut0 (
		.aclk(aclk),
		.reset_i(reset),
		.axil_i(axil_req),
		.axil_o(axil_rsp),
		.phy_int_i(phy_int),
		.mdio_i(mdio_in),
		.intr_o(intr),
		.reset_request_o(reset_request),
		.phy_reset_o(phy_reset),
		.mdc_o(mdc),
		.mdio_o(mdio_out),
		.mdio_oe_o(mdio_oe)
	);

	initial
	begin
		aclk = 1'b0;
		forever
			#5 aclk = ~aclk;
	end

	// Hard stop if something hangs
	initial
	begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES)
		begin
			@(posedge aclk);
			cycle_cnt++;
		end
		$display("Timeout: run did not finish within %0d cycles", cycle_cnt);
		$display("Test FAILED");
		$finish;
	end

	// Count reset request pulses
	always @(negedge aclk)
	begin
		if (reset_request)
			rst_pulses++;
	end

	// LCG with the Numerical Recipes constants
	function automatic logic [31:0] next_random();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		assert (actual === expected)
		else
		begin
			errors++;
			$display("[FAIL] %s: %s expected %h actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		errors_at_start = errors;
	endtask

	task automatic finish_test();
		$display("%-12s %s (%0d errors)", test_name,
			(errors == errors_at_start) ? "passed" : "failed", errors - errors_at_start);
	endtask

	task automatic bus_write(input logic [15:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output logic [1:0] resp);
		@(posedge aclk);
		axil_req.awaddr <= addr;
		axil_req.awvalid <= 1'b1;
		axil_req.wdata <= data;
		axil_req.wstrb <= strb;
		axil_req.wvalid <= 1'b1;
		// Address and data go in together
		do
			@(negedge aclk);
		while (!axil_rsp.awready);
		// Both ready strobes come in the same cycle
		check_value("wready", 32'h1, {31'b0, axil_rsp.wready});
		@(posedge aclk);
		axil_req.awvalid <= 1'b0;
		axil_req.wvalid <= 1'b0;
		do
			@(negedge aclk);
		while (!axil_rsp.bvalid);
		resp = axil_rsp.bresp;
		// Random stall before taking the response
		repeat (next_random() % 32'd3)
			@(posedge aclk);
		@(posedge aclk);
		axil_req.bready <= 1'b1;
		@(posedge aclk);
		axil_req.bready <= 1'b0;
	endtask

	task automatic bus_read(input logic [15:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		@(posedge aclk);
		axil_req.araddr <= addr;
		axil_req.arvalid <= 1'b1;
		do
			@(negedge aclk);
		while (!axil_rsp.arready);
		@(posedge aclk);
		axil_req.arvalid <= 1'b0;
		do
			@(negedge aclk);
		while (!axil_rsp.rvalid);
		data = axil_rsp.rdata;
		resp = axil_rsp.rresp;
		repeat (next_random() % 32'd3)
			@(posedge aclk);
		@(posedge aclk);
		axil_req.rready <= 1'b1;
		@(posedge aclk);
		axil_req.rready <= 1'b0;
	endtask

	task automatic write_expect_okay(input logic [15:0] addr, input logic [31:0] data);
		logic [1:0] resp;
		bus_write(addr, data, 4'hF, resp);
		check_value("bresp", 32'h0, {30'b0, resp});
	endtask

	task automatic read_expect_okay(input logic [15:0] addr, output logic [31:0] data);
		logic [1:0] resp;
		bus_read(addr, data, resp);
		check_value("rresp", 32'h0, {30'b0, resp});
	endtask

	// Poll MDIC until R comes back
	task automatic wait_mdio_done(output logic [31:0] mdic);
		do
			read_expect_okay(MDIC, mdic);
		while (!mdic[MDIC_R_BIT]);
	endtask

	// Pulse, then give the synchroniser and intr_o time to settle
	task automatic pulse_phy_int();
		@(posedge aclk);
		phy_int <= 1'b1;
		repeat (2) @(posedge aclk);
		phy_int <= 1'b0;
		repeat (4) @(posedge aclk);
		@(negedge aclk);
	endtask

	// Clause-22 PHY model clocked by mdc
	initial
	begin : phy_model
		logic [1:0]  op;
		logic [4:0]  phyad;
		logic [4:0]  regad;
		logic [15:0] wdata;
		mdio_in = 1'b1;
		phy_writes = 0;
		phy_reads = 0;
		for (int i = 0; i < 32; i++)
			phy_regs[i] = 16'(i * 32'h0000_0731 + 32'h0000_51c3);
		forever
		begin
			@(posedge mdc);
			// First zero after the preamble is ST
			if (mdio_oe && !mdio_out)
			begin
				@(posedge mdc);
				for (int b = 0; b < 2; b++)
				begin
					@(posedge mdc);
					op = {op[0], mdio_out};
				end
				for (int b = 0; b < 5; b++)
				begin
					@(posedge mdc);
					phyad = {phyad[3:0], mdio_out};
				end
				for (int b = 0; b < 5; b++)
				begin
					@(posedge mdc);
					regad = {regad[3:0], mdio_out};
				end
				if (op == 2'b10)
				begin
					// Second TA bit driven low, then data MSB first
					repeat (2) @(negedge mdc);
					mdio_in <= 1'b0;
					for (int b = 15; b >= 0; b--)
					begin
						@(negedge mdc);
						mdio_in <= phy_regs[regad][b];
					end
					@(negedge mdc);
					mdio_in <= 1'b1;
					phy_reads++;
				end
				else
				begin
					repeat (2) @(posedge mdc);
					for (int b = 0; b < 16; b++)
					begin
						@(posedge mdc);
						wdata = {wdata[14:0], mdio_out};
					end
					phy_regs[regad] = wdata;
					phy_last_op = op;
					phy_last_phyad = phyad;
					phy_last_regad = regad;
					phy_last_data = wdata;
					phy_writes++;
				end
			end
		end
	end

	initial
	begin : main
		logic [31:0] data;
		logic [31:0] sel;
		logic [31:0] rd;
		logic [31:0] expected;
		logic [31:0] mask_model;
		logic [31:0] cause_model;
		logic [15:0] addr;
		logic [1:0]  resp;
		logic [4:0]  regad;
		int          writes_before;
		int          reads_before;
		int          pulses_before;
		rand_state = 32'hee17c2d4;
		errors = 0;
		checks = 0;
		rst_pulses = 0;
		axil_req = '0;
		phy_int = 1'b0;
		reset = 1'b1;
		mask_model = '0;
		cause_model = '0;
		repeat (2) @(posedge aclk);
		reset <= 1'b0;

		start_test("masks");
		for (int i = 0; i < 12; i++)
		begin
			data = next_random();
			sel = next_random();
			if (sel[8])
			begin
				write_expect_okay(IMS, data);
				mask_model = mask_model | data;
			end
			else
			begin
				write_expect_okay(IMC, data);
				mask_model = mask_model & ~data;
			end
			read_expect_okay(IMS, rd);
			check_value("IMS", mask_model, rd);
		end
		// Everything at 0x100 and up is unmapped
		for (int i = 0; i < 4; i++)
		begin
			data = next_random();
			addr = (data[15:0] | 16'h0100) & 16'hFFFC;
			bus_read(addr, rd, resp);
			check_value("unmapped rresp", 32'h2, {30'b0, resp});
			check_value("unmapped rdata", 32'h0, rd);
			bus_write(addr, data, 4'hF, resp);
			check_value("unmapped bresp", 32'h2, {30'b0, resp});
		end
		finish_test();

		start_test("causes");
		for (int i = 0; i < 8; i++)
		begin
			// Single bits so intr_o goes both ways against the random mask
			data = next_random();
			data = 32'h1 << data[4:0];
			write_expect_okay(ICS, data);
			cause_model = cause_model | data;
			data = next_random();
			data = 32'h1 << data[9:5];
			write_expect_okay(ICS, data);
			cause_model = cause_model | data;
			@(negedge aclk);
			check_value("intr_o", {31'b0, |(cause_model & mask_model)}, {31'b0, intr});
			read_expect_okay(ICR, rd);
			check_value("ICR", cause_model, rd);
			cause_model = '0;
			read_expect_okay(ICR, rd);
			check_value("ICR after clear", 32'h0, rd);
			@(negedge aclk);
			check_value("intr_o after clear", 32'h0, {31'b0, intr});
		end
		finish_test();

		start_test("mdio write");
		for (int i = 0; i < N_MDIO_WR; i++)
		begin
			data = next_random();
			regad = data[20:16];
			writes_before = phy_writes;
			write_expect_okay(MDIC, {4'b0000, 2'b01, 5'b0, regad, data[15:0]});
			wait_mdio_done(rd);
			check_value("PHY write count", 32'(writes_before + 1), 32'(phy_writes));
			check_value("PHY opcode", 32'h1, {30'b0, phy_last_op});
			check_value("PHY address", {27'b0, PHY_ADDR}, {27'b0, phy_last_phyad});
			check_value("PHY regad", {27'b0, regad}, {27'b0, phy_last_regad});
			check_value("PHY data", {16'b0, data[15:0]}, {16'b0, phy_last_data});
			check_value("MDIC", {4'b0001, 2'b01, PHY_ADDR, regad, data[15:0]}, rd);
			read_expect_okay(ICR, rd);
			check_value("MDAC cause", 32'h1 << CAUSE_MDAC, rd);
		end
		finish_test();

		start_test("mdio read");
		for (int i = 0; i < N_MDIO_RD; i++)
		begin
			data = next_random();
			regad = data[4:0];
			writes_before = phy_writes;
			reads_before = phy_reads;
			write_expect_okay(MDIC, {4'b0000, 2'b10, 5'b0, regad, 16'h0});
			// Lands while the frame runs and gets dropped
			write_expect_okay(MDIC, {4'b0000, 2'b01, 5'b0, ~regad, data[31:16]});
			wait_mdio_done(rd);
			expected = {4'b0001, 2'b10, PHY_ADDR, regad, phy_regs[regad]};
			check_value("MDIC read data", expected, rd);
			check_value("PHY write count", 32'(writes_before), 32'(phy_writes));
			check_value("PHY read count", 32'(reads_before + 1), 32'(phy_reads));
			read_expect_okay(ICR, rd);
			check_value("MDAC cause", 32'h1 << CAUSE_MDAC, rd);
		end
		finish_test();

		start_test("phy int");
		write_expect_okay(IMC, 32'hFFFF_FFFF);
		mask_model = '0;
		pulse_phy_int();
		check_value("intr_o masked", 32'h0, {31'b0, intr});
		read_expect_okay(ICR, rd);
		check_value("PHYINT cause", 32'h1 << CAUSE_PHYINT, rd);
		write_expect_okay(IMS, 32'h1 << CAUSE_PHYINT);
		mask_model = 32'h1 << CAUSE_PHYINT;
		pulse_phy_int();
		check_value("intr_o unmasked", 32'h1, {31'b0, intr});
		read_expect_okay(ICR, rd);
		check_value("PHYINT cause", 32'h1 << CAUSE_PHYINT, rd);
		@(negedge aclk);
		check_value("intr_o after clear", 32'h0, {31'b0, intr});
		finish_test();

		start_test("control");
		data = next_random();
		data[26] = 1'b1;
		data[31] = 1'b0;
		pulses_before = rst_pulses;
		write_expect_okay(CTRL, data);
		repeat (2) @(negedge aclk);
		check_value("reset request pulses", 32'h1, 32'(rst_pulses - pulses_before));
		read_expect_okay(CTRL, rd);
		check_value("CTRL", data & ~(32'h1 << 26), rd);
		check_value("phy_reset_o low", 32'h0, {31'b0, phy_reset});
		write_expect_okay(CTRL, 32'h8000_0000);
		@(negedge aclk);
		check_value("phy_reset_o high", 32'h1, {31'b0, phy_reset});
		read_expect_okay(CTRL, rd);
		check_value("CTRL", 32'h8000_0000, rd);
		write_expect_okay(CTRL, 32'h0);
		@(negedge aclk);
		check_value("phy_reset_o released", 32'h0, {31'b0, phy_reset});
		finish_test();

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire
